/* bench/tb_te_packet_emitter.sv */
// ##########################################################
// testbench for the trace packet emitter, drives each format
// and checks payload, length and outputs against a model
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "te_consts.svh"

module tb_te_packet_emitter;

    import te_pkg::*;

    localparam int CLK_HALF_NS    = 20;
    localparam int RESET_CYCLES   = 10;
    localparam int DRIVE_DELAY_NS = 2;
    localparam int WAIT_CYCLES    = 4;
    localparam int WATCHDOG_NS    = 200000;
    localparam int TVEC_LEN       = `TE_XLEN - 2;

    logic                            clk_i = 1'b0;
    logic                            rst_ni;
    logic                            valid_i;
    te_format_e                      format_i;
    te_sync_subformat_e              subformat_i;
    logic [`TE_CAUSE_LEN-1:0]        lc_cause_i;
    logic [`TE_CAUSE_LEN-1:0]        tc_cause_i;
    logic [`TE_XLEN-1:0]             lc_tval_i;
    logic [`TE_XLEN-1:0]             tc_tval_i;
    logic                            lc_interrupt_i;
    logic                            tc_interrupt_i;
    logic                            lc_tc_mux_i;
    logic                            tc_branch_i;
    logic                            tc_branch_taken_i;
    logic [`TE_PRIV_LEN-1:0]         tc_priv_i;
    logic [`TE_XLEN-1:0]             tc_iaddr_i;
    logic                            thaddr_i;
    logic [TVEC_LEN-1:0]             tc_tvec_i;
    logic [`TE_XLEN-1:0]             lc_epc_i;
    logic                            tc_ienable_i;
    logic                            encoder_mode_i;
    te_qual_status_e                 qual_status_i;
    te_ioptions_e                    ioptions_i;
    logic                            lc_updiscon_i;
    logic [`TE_BRANCH_COUNT_LEN-1:0] branches_i;
    logic [`TE_BRANCH_MAP_LEN-1:0]   branch_map_i;
    logic [`TE_KEEP_BITS_LEN-1:0]    keep_bits_i;
    logic                            packet_valid_o;
    logic [`TE_PAYLOAD_LEN-1:0]      packet_payload_o;
    logic [`TE_P_LEN-1:0]            payload_length_o;
    logic                            branch_map_flush_o;
    logic [`TE_XLEN-1:0]             addr_to_compress_o;

    // expected packet, built field by field
    logic [`TE_PAYLOAD_LEN-1:0] exp_payload;
    int                         exp_used;
    logic [`TE_XLEN-1:0]        exp_atc;
    logic                       exp_update;
    // model of the stored address
    logic [`TE_XLEN-1:0]        model_latest = '0;
    logic [31:0]                lfsr_q = 32'h29cb3d53;
    int                         errors = 0;
    int                         checks = 0;
    int                         branch_counts[7] = '{0, 1, 9, 10, 25, 26, 31};

    te_packet_emitter UUT (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .valid_i            (valid_i),
        .format_i           (format_i),
        .subformat_i        (subformat_i),
        .lc_cause_i         (lc_cause_i),
        .lc_tval_i          (lc_tval_i),
        .lc_interrupt_i     (lc_interrupt_i),
        .tc_cause_i         (tc_cause_i),
        .tc_tval_i          (tc_tval_i),
        .tc_interrupt_i     (tc_interrupt_i),
        .lc_tc_mux_i        (lc_tc_mux_i),
        .tc_branch_i        (tc_branch_i),
        .tc_branch_taken_i  (tc_branch_taken_i),
        .tc_priv_i          (tc_priv_i),
        .tc_iaddr_i         (tc_iaddr_i),
        .thaddr_i           (thaddr_i),
        .tc_tvec_i          (tc_tvec_i),
        .lc_epc_i           (lc_epc_i),
        .tc_ienable_i       (tc_ienable_i),
        .encoder_mode_i     (encoder_mode_i),
        .qual_status_i      (qual_status_i),
        .ioptions_i         (ioptions_i),
        .lc_updiscon_i      (lc_updiscon_i),
        .branches_i         (branches_i),
        .branch_map_i       (branch_map_i),
        .keep_bits_i        (keep_bits_i),
        .packet_valid_o     (packet_valid_o),
        .packet_payload_o   (packet_payload_o),
        .payload_length_o   (payload_length_o),
        .branch_map_flush_o (branch_map_flush_o),
        .addr_to_compress_o (addr_to_compress_o)
    );

    always #CLK_HALF_NS clk_i = ~clk_i;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r = {r[62:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // branch map bits sent for a given count
    function automatic int map_size(input int b);
        if (b == 0) return 0;
        if (b == 1) return 1;
        if (b <= 9) return 9;
        if (b <= 17) return 17;
        if (b <= 25) return 25;
        return 31;
    endfunction

    // whole bytes covering the kept bits, never above a full word
    function automatic int bytes_kept(input int kb);
        return (kb > 64) ? 8 : (kb + 7) / 8;
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("ERROR: timeout, %s (errors so far %0d)", what, errors);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [`TE_PAYLOAD_LEN-1:0] expected,
                               input logic [`TE_PAYLOAD_LEN-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %s (%s): expected %h, actual %h", test, what, expected, actual);
        end
    endtask

    // next field sits right above the previous one
    task automatic append_bits(input logic [63:0] value, input int width);
        logic [`TE_PAYLOAD_LEN-1:0] field;
        field = `TE_PAYLOAD_LEN'(value) & ~({`TE_PAYLOAD_LEN{1'b1}} << width);
        exp_payload = exp_payload | (field << exp_used);
        exp_used = exp_used + width;
    endtask

    task automatic build_expected();
        int          a;
        logic [63:0] diff;
        logic [63:0] taddr;
        logic        notify;
        logic        updiscon;
        logic        br;
        a = bytes_kept(int'(keep_bits_i)) * 8;
        diff = tc_iaddr_i - model_latest;
        taddr = thaddr_i ? {tc_tvec_i, 2'b00} : lc_epc_i;
        br = !(tc_branch_i && tc_branch_taken_i);
        notify = tc_iaddr_i[63];
        updiscon = lc_updiscon_i ? !notify : notify;
        exp_payload = '0;
        exp_used = 0;
        exp_atc = '0;
        exp_update = 1'b0;
        if (valid_i) begin
            append_bits(64'(format_i), 2);
            if (format_i == F_SYNC) begin
                append_bits(64'(subformat_i), 2);
                case (subformat_i)
                    SF_SUPPORT: begin
                        append_bits(64'(ioptions_i), 3);
                        append_bits(64'(qual_status_i), 2);
                        append_bits(64'(encoder_mode_i), 1);
                        append_bits(64'(tc_ienable_i), 1);
                    end
                    SF_CONTEXT: begin
                        append_bits(64'(tc_priv_i), 2);
                    end
                    SF_START: begin
                        append_bits(64'(tc_priv_i), 2);
                        append_bits(64'(br), 1);
                        append_bits(tc_iaddr_i, a);
                        exp_atc = tc_iaddr_i;
                        exp_update = 1'b1;
                    end
                    default: begin
                        // trap record from the selected cycle
                        append_bits(64'(lc_tc_mux_i ? tc_interrupt_i : lc_interrupt_i), 1);
                        append_bits(64'(lc_tc_mux_i ? tc_cause_i : lc_cause_i), 5);
                        append_bits(64'(tc_priv_i), 2);
                        append_bits(64'(br), 1);
                        append_bits(lc_tc_mux_i ? tc_tval_i : lc_tval_i, 64);
                        append_bits(taddr, a);
                        if (ioptions_i == FULL_ADDRESS) begin
                            exp_atc = taddr;
                        end
                        exp_update = 1'b1;
                    end
                endcase
            end else begin
                if (format_i == F_DIFF_DELTA) begin
                    append_bits(64'(branches_i), 5);
                    append_bits(64'(branch_map_i), map_size(int'(branches_i)));
                end
                // address tail, left out only for a full map
                if (format_i == F_ADDR_ONLY || branches_i < 5'd31) begin
                    append_bits(diff, a);
                    append_bits(64'(notify), 1);
                    append_bits(64'(updiscon), 1);
                    append_bits(64'(updiscon), 1);
                    append_bits(64'(updiscon), 1);
                end
                if (ioptions_i != FULL_ADDRESS) begin
                    exp_atc = diff;
                end
                exp_update = 1'b1;
            end
        end
    endtask

    // samples taken until packet_valid_o matched, 1 means same cycle
    task automatic wait_valid_level(input logic level, output int samples);
        logic seen;
        seen = 1'b0;
        samples = 0;
        while (!seen && samples < WAIT_CYCLES) begin
            @(negedge clk_i);
            seen = (packet_valid_o === level);
            samples++;
        end
        if (!seen) begin
            errors++;
            $display("ERROR: timeout, packet_valid_o never followed valid_i");
        end
    endtask

    task automatic check_packet(input string test);
        int samples;
        wait_valid_level(valid_i, samples);
        build_expected();
        // outputs are combinational, no cycle of latency
        check_value(test, "latency", `TE_PAYLOAD_LEN'(0), `TE_PAYLOAD_LEN'(samples - 1));
        check_value(test, "payload", exp_payload, packet_payload_o);
        check_value(test, "length", `TE_PAYLOAD_LEN'((exp_used + 7) / 8), payload_length_o);
        check_value(test, "flush", valid_i, branch_map_flush_o);
        check_value(test, "addr_to_compress", exp_atc, addr_to_compress_o);
        // loaded at the edge that ends this cycle
        if (exp_update) begin
            model_latest = tc_iaddr_i;
        end
    endtask

    task automatic idle_inputs();
        valid_i = 1'b0;
        format_i = F_SYNC;
        subformat_i = SF_START;
        lc_cause_i = '0;
        tc_cause_i = '0;
        lc_tval_i = '0;
        tc_tval_i = '0;
        lc_interrupt_i = 1'b0;
        tc_interrupt_i = 1'b0;
        lc_tc_mux_i = 1'b0;
        tc_branch_i = 1'b0;
        tc_branch_taken_i = 1'b0;
        tc_priv_i = '0;
        tc_iaddr_i = '0;
        thaddr_i = 1'b0;
        tc_tvec_i = '0;
        lc_epc_i = '0;
        tc_ienable_i = 1'b0;
        encoder_mode_i = 1'b0;
        qual_status_i = NO_CHANGE;
        ioptions_i = DELTA_ADDRESS;
        lc_updiscon_i = 1'b0;
        branches_i = '0;
        branch_map_i = '0;
        keep_bits_i = '0;
    endtask

    // new cycle with random fields, then the packet kind
    task automatic start_cycle(input logic valid, input te_format_e fmt,
                               input te_sync_subformat_e sub);
        @(posedge clk_i);
        #DRIVE_DELAY_NS;
        lc_cause_i = 5'(rand_bits(5));
        tc_cause_i = 5'(rand_bits(5));
        lc_tval_i = rand_bits(64);
        tc_tval_i = rand_bits(64);
        lc_interrupt_i = 1'(rand_bits(1));
        tc_interrupt_i = 1'(rand_bits(1));
        lc_tc_mux_i = 1'(rand_bits(1));
        tc_branch_i = 1'(rand_bits(1));
        tc_branch_taken_i = 1'(rand_bits(1));
        tc_priv_i = 2'(rand_bits(2));
        tc_iaddr_i = rand_bits(64);
        thaddr_i = 1'(rand_bits(1));
        tc_tvec_i = TVEC_LEN'(rand_bits(TVEC_LEN));
        lc_epc_i = rand_bits(64);
        tc_ienable_i = 1'(rand_bits(1));
        encoder_mode_i = 1'(rand_bits(1));
        qual_status_i = te_qual_status_e'(2'(rand_bits(2)));
        ioptions_i = (rand_bits(1) != 0) ? FULL_ADDRESS : DELTA_ADDRESS;
        lc_updiscon_i = 1'(rand_bits(1));
        branches_i = 5'(rand_bits(5));
        branch_map_i = 31'(rand_bits(31));
        keep_bits_i = 7'(rand_bits(7) % 65);
        valid_i = valid;
        format_i = fmt;
        subformat_i = sub;
    endtask

    initial begin
        int i;
        int kb;
        idle_inputs();
        rst_ni = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY_NS;
        rst_ni = 1'b1;

        // nothing sent and nothing stored while valid_i is low
        start_cycle(1'b0, F_SYNC, SF_START);
        check_packet("valid_low_after_reset");
        // stored address still zero from reset
        start_cycle(1'b1, F_ADDR_ONLY, SF_START);
        keep_bits_i = 7'd64;
        check_packet("first_diff_from_reset");
        for (i = 0; i < 4; i++) begin
            start_cycle(1'b0, F_DIFF_DELTA, SF_TRAP);
            check_packet("valid_low_idle");
        end
        start_cycle(1'b1, F_ADDR_ONLY, SF_START);
        keep_bits_i = 7'd64;
        check_packet("diff_after_idle");

        for (i = 0; i < 8; i++) begin
            start_cycle(1'b1, F_SYNC, SF_SUPPORT);
            check_packet("support");
            check_value("support", "bytes", `TE_PAYLOAD_LEN'(2), payload_length_o);
            start_cycle(1'b1, F_SYNC, SF_CONTEXT);
            check_packet("context");
            check_value("context", "bytes", `TE_PAYLOAD_LEN'(1), payload_length_o);
        end

        // every keep_bits value of a full word
        for (kb = 0; kb <= 64; kb++) begin
            start_cycle(1'b1, F_SYNC, SF_START);
            keep_bits_i = 7'(kb);
            check_packet("start_keep_bits");
        end

        for (i = 0; i < 24; i++) begin
            start_cycle(1'b1, F_SYNC, SF_TRAP);
            check_packet("trap");
        end

        // format 2 right after a start, updiscon low then high
        for (i = 0; i < 8; i++) begin
            start_cycle(1'b1, F_SYNC, SF_START);
            keep_bits_i = 7'd64;
            check_packet("start_before_diff");
            start_cycle(1'b1, F_ADDR_ONLY, SF_START);
            lc_updiscon_i = 1'(i % 2);
            check_packet("addr_only_diff");
        end

        foreach (branch_counts[j]) begin
            start_cycle(1'b1, F_DIFF_DELTA, SF_START);
            branches_i = 5'(branch_counts[j]);
            check_packet("diff_delta_branches");
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // hard limit on the whole run
    initial begin
        #WATCHDOG_NS;
        stop_on_timeout("watchdog expired before the end of the test");
    end

endmodule

`default_nettype wire

/* common/te_addr_if.sv */
// ##########################################################
// address values between the address unit and the packer
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "te_consts.svh"

interface te_addr_if;

    logic [`TE_XLEN-1:0]           diff_addr;
    logic [`TE_XLEN-1:0]           trap_addr;
    logic [`TE_ADDR_BYTES_LEN-1:0] addr_bytes;
    // packer asks to store the current address
    logic                          update_latest;

    modport unit (output diff_addr, trap_addr, addr_bytes, input update_latest);
    modport pack (input diff_addr, trap_addr, addr_bytes, output update_latest);

endinterface

`default_nettype wire

/* common/te_consts.svh */
// ##########################################################
// widths and lengths shared by the trace packet emitter
// include wherever a field width or payload size is needed
// ##########################################################
`ifndef TE_CONSTS_SVH
`define TE_CONSTS_SVH

// address and data word
`define TE_XLEN             64
`define TE_PRIV_LEN         2
`define TE_CAUSE_LEN        5
// branch count and map from the branch map unit
`define TE_BRANCH_COUNT_LEN 5
`define TE_BRANCH_MAP_LEN   31
// compression control, byte count 0 to 8
`define TE_KEEP_BITS_LEN    7
`define TE_ADDR_BYTES_LEN   4
// longest packet is a trap with full address, 141 bits
`define TE_PAYLOAD_LEN      144
`define TE_P_LEN            8

`endif

/* common/te_fields_if.sv */
// ##########################################################
// selected packet fields, field selector to payload packer
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "te_consts.svh"

interface te_fields_if;

    // 1 unless a taken branch
    logic                      branch;
    // trap info, last or this cycle
    logic [`TE_CAUSE_LEN-1:0]  ecause;
    logic                      interrupt;
    logic [`TE_XLEN-1:0]       tval;
    // format 1 and 2 tail bits
    logic                      notify;
    logic                      updiscon;
    logic                      irreport;
    logic                      irdepth;

    modport sel  (output branch, ecause, interrupt, tval, notify, updiscon, irreport, irdepth);
    modport pack (input  branch, ecause, interrupt, tval, notify, updiscon, irreport, irdepth);

endinterface

`default_nettype wire

/* common/te_pkg.sv */
// ##########################################################
// packet format and option encodings of the trace encoder
// ##########################################################
`default_nettype none

package te_pkg;

    // two bit format field at the start of every packet
    typedef enum logic [1:0] {
        F_OPT_EXT    = 2'h0,
        F_DIFF_DELTA = 2'h1,
        F_ADDR_ONLY  = 2'h2,
        F_SYNC       = 2'h3
    } te_format_e;

    // subformats of format 3
    typedef enum logic [1:0] {
        SF_START   = 2'h0,
        SF_TRAP    = 2'h1,
        SF_CONTEXT = 2'h2,
        SF_SUPPORT = 2'h3
    } te_sync_subformat_e;

    // qualification status reported in support packets
    typedef enum logic [1:0] {
        NO_CHANGE  = 2'h0,
        ENDED_REP  = 2'h1,
        TRACE_LOST = 2'h2,
        ENDED_NTR  = 2'h3
    } te_qual_status_e;

    // instruction trace options
    typedef enum logic [2:0] {
        DELTA_ADDRESS      = 3'h0,
        FULL_ADDRESS       = 3'h1,
        IMPLICIT_EXCEPTION = 3'h2,
        SEQUENTIAL_JUMP    = 3'h3,
        IMPLICIT_RETURN    = 3'h4,
        BRANCH_PREDICTION  = 3'h5,
        JUMP_TARGET_CACHE  = 3'h6
    } te_ioptions_e;

endpackage

`default_nettype wire

/* design/packer/te_payload_packer.sv */
// ##########################################################
// lays out the payload of each packet format and counts
// its length, also picks the address sent back for compression
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "te_consts.svh"

module te_payload_packer (
    input  logic                             valid_i,
    input  te_pkg::te_format_e               format_i,
    input  te_pkg::te_sync_subformat_e       subformat_i,
    input  logic [`TE_PRIV_LEN-1:0]          tc_priv_i,
    input  logic [`TE_XLEN-1:0]              tc_iaddr_i,
    input  logic                             tc_ienable_i,
    input  logic                             encoder_mode_i,
    input  te_pkg::te_qual_status_e          qual_status_i,
    input  te_pkg::te_ioptions_e             ioptions_i,
    input  logic [`TE_BRANCH_COUNT_LEN-1:0]  branches_i,
    input  logic [`TE_BRANCH_MAP_LEN-1:0]    branch_map_i,
    te_fields_if.pack                        fields_i,
    te_addr_if.pack                          addr_i,
    output logic                             packet_valid_o,
    output logic                             branch_map_flush_o,
    output logic [`TE_PAYLOAD_LEN-1:0]       packet_payload_o,
    output logic [`TE_P_LEN-1:0]             payload_length_o,
    output logic [`TE_XLEN-1:0]              addr_to_compress_o
);

    import te_pkg::*;

    typedef logic [`TE_PAYLOAD_LEN-1:0] payload_t;
    // compressed address followed by the four flag bits
    typedef logic [`TE_XLEN+3:0]        tail_t;

    logic [7:0]                   a_bits;
    logic [`TE_XLEN-1:0]          addr_mask;
    logic [5:0]                   map_len;
    logic [`TE_BRANCH_MAP_LEN-1:0] map_cut;
    tail_t                        addr_tail;
    logic                         is_trap;
    logic                         is_start;
    logic                         is_diff;
    payload_t                     payload;
    logic [7:0]                   used_bits;

    // address width in bits, then a mask of its low bytes
    assign a_bits    = {1'b0, addr_i.addr_bytes, 3'b000};
    assign addr_mask = ~({`TE_XLEN{1'b1}} << a_bits);

    // map cut to the smallest size holding all branches
    always_comb begin
        if (branches_i == '0) begin
            map_len = 6'd0;
        end else if (branches_i == 5'd1) begin
            map_len = 6'd1;
        end else if (branches_i <= 5'd9) begin
            map_len = 6'd9;
        end else if (branches_i <= 5'd17) begin
            map_len = 6'd17;
        end else if (branches_i <= 5'd25) begin
            map_len = 6'd25;
        end else begin
            map_len = 6'd31;
        end
    end

    assign map_cut = branch_map_i & ~({`TE_BRANCH_MAP_LEN{1'b1}} << map_len);

    // shared by format 2 and format 1 with address
    assign addr_tail = tail_t'(addr_i.diff_addr & addr_mask)
                     | (tail_t'({fields_i.irdepth, fields_i.irreport,
                                 fields_i.updiscon, fields_i.notify}) << a_bits);

    assign is_trap  = (format_i == F_SYNC) && (subformat_i == SF_TRAP);
    assign is_start = (format_i == F_SYNC) && (subformat_i == SF_START);
    assign is_diff  = (format_i == F_ADDR_ONLY) || (format_i == F_DIFF_DELTA);

    always_comb begin
        payload   = '0;
        used_bits = '0;
        if (valid_i) begin
            // format in bits 1:0 for every packet
            payload   = payload_t'(format_i);
            used_bits = 8'd2;
            case (format_i)
                F_SYNC: begin
                    payload = payload | (payload_t'(subformat_i) << 2);
                    case (subformat_i)
                        SF_START: begin
                            payload = payload | (payload_t'({tc_iaddr_i & addr_mask,
                                fields_i.branch, tc_priv_i}) << 4);
                            used_bits = 8'd7 + a_bits;
                        end
                        SF_TRAP: begin
                            // interrupt lowest, trap address on top
                            payload = payload | (payload_t'({addr_i.trap_addr & addr_mask,
                                fields_i.tval, fields_i.branch, tc_priv_i,
                                fields_i.ecause, fields_i.interrupt}) << 4);
                            used_bits = 8'd77 + a_bits;
                        end
                        SF_CONTEXT: begin
                            payload   = payload | (payload_t'(tc_priv_i) << 4);
                            used_bits = 8'd6;
                        end
                        default: begin
                            // support
                            payload = payload | (payload_t'({tc_ienable_i, encoder_mode_i,
                                qual_status_i, ioptions_i}) << 4);
                            used_bits = 8'd11;
                        end
                    endcase
                end
                F_ADDR_ONLY: begin
                    payload   = payload | (payload_t'(addr_tail) << 2);
                    used_bits = 8'd6 + a_bits;
                end
                F_DIFF_DELTA: begin
                    payload   = payload | (payload_t'({map_cut, branches_i}) << 2);
                    used_bits = 8'd7 + 8'(map_len);
                    // full map carries no address
                    if (branches_i < 5'd31) begin
                        payload   = payload | (payload_t'(addr_tail) << (8'd7 + 8'(map_len)));
                        used_bits = used_bits + 8'd4 + a_bits;
                    end
                end
                default: begin
                    // format 0 not built, empty packet
                    payload   = '0;
                    used_bits = '0;
                end
            endcase
        end
    end

    assign packet_payload_o   = payload;
    // used bits rounded up to bytes
    assign payload_length_o   = `TE_P_LEN'((9'(used_bits) + 9'd7) >> 3);
    assign packet_valid_o     = valid_i;
    // map consumed by every packet
    assign branch_map_flush_o = valid_i;

    assign addr_i.update_latest = valid_i && (is_start || is_trap || is_diff);

    // address handed back to the compression logic
    always_comb begin
        if (!valid_i) begin
            addr_to_compress_o = '0;
        end else if (is_trap && (ioptions_i == FULL_ADDRESS)) begin
            addr_to_compress_o = addr_i.trap_addr;
        end else if (is_start) begin
            addr_to_compress_o = tc_iaddr_i;
        end else if (is_diff && (ioptions_i != FULL_ADDRESS)) begin
            addr_to_compress_o = addr_i.diff_addr;
        end else begin
            addr_to_compress_o = '0;
        end
    end

endmodule

`default_nettype wire

/* design/te_addr_unit.sv */
// ##########################################################
// last emitted address, its difference to the current pc,
// trap address and number of address bytes to keep
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "te_consts.svh"

module te_addr_unit (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic [`TE_XLEN-1:0]          tc_iaddr_i,
    input  logic [`TE_XLEN-1:0]          lc_epc_i,
    input  logic [`TE_XLEN-3:0]          tc_tvec_i,
    input  logic                         thaddr_i,
    input  logic [`TE_KEEP_BITS_LEN-1:0] keep_bits_i,
    te_addr_if.unit                      addr_o
);

    logic [`TE_XLEN-1:0]          latest_addr_q;
    logic [`TE_KEEP_BITS_LEN-1:0] keep_sum;

    // address carried by the last start, trap, format 1 or 2 packet
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            latest_addr_q <= '0;
        end else if (addr_o.update_latest) begin
            latest_addr_q <= tc_iaddr_i;
        end
    end

    // modulo 2^xlen difference
    assign addr_o.diff_addr = tc_iaddr_i - latest_addr_q;

    // handler address is word aligned, else return to epc
    assign addr_o.trap_addr = thaddr_i ? {tc_tvec_i, 2'b00} : lc_epc_i;

    // bits rounded up to whole bytes
    assign keep_sum = keep_bits_i + `TE_KEEP_BITS_LEN'(7);
    // anything past a full word keeps all 8 bytes
    assign addr_o.addr_bytes = (keep_bits_i > `TE_KEEP_BITS_LEN'(`TE_XLEN)) ?
                               `TE_ADDR_BYTES_LEN'(8) : keep_sum[6:3];

endmodule

`default_nettype wire

/* design/te_field_select.sv */
// ##########################################################
// picks last or this cycle trap info and derives the
// branch and discontinuity bits for the packer
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "te_consts.svh"

module te_field_select (
    input  logic [`TE_CAUSE_LEN-1:0] lc_cause_i,
    input  logic [`TE_CAUSE_LEN-1:0] tc_cause_i,
    input  logic [`TE_XLEN-1:0]      lc_tval_i,
    input  logic [`TE_XLEN-1:0]      tc_tval_i,
    input  logic [`TE_XLEN-1:0]      tc_iaddr_i,
    input  logic                     lc_interrupt_i,
    input  logic                     tc_interrupt_i,
    input  logic                     lc_tc_mux_i,
    input  logic                     tc_branch_i,
    input  logic                     tc_branch_taken_i,
    input  logic                     lc_updiscon_i,
    te_fields_if.sel                 fields_o
);

    logic notify;
    logic updiscon;

    // branch bit is 0 only for a taken branch
    assign fields_o.branch = ~(tc_branch_i & tc_branch_taken_i);

    // one select for the whole trap record
    assign fields_o.ecause    = lc_tc_mux_i ? tc_cause_i     : lc_cause_i;
    assign fields_o.interrupt = lc_tc_mux_i ? tc_interrupt_i : lc_interrupt_i;
    assign fields_o.tval      = lc_tc_mux_i ? tc_tval_i      : lc_tval_i;

    // notify mirrors the address msb, no trigger unit here
    assign notify = tc_iaddr_i[`TE_XLEN-1];
    // inverted after an uninferable discontinuity
    assign updiscon = lc_updiscon_i ? ~notify : notify;

    assign fields_o.notify   = notify;
    assign fields_o.updiscon = updiscon;
    // no implicit return, both follow updiscon
    assign fields_o.irreport = updiscon;
    assign fields_o.irdepth  = updiscon;

endmodule

`default_nettype wire

/* design/te_packet_emitter.sv */
// ##########################################################
// trace packet emitter top, one packet per valid cycle
// all outputs combinational on the current inputs
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "te_consts.svh"

module te_packet_emitter (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             valid_i,
    input  te_pkg::te_format_e               format_i,
    input  te_pkg::te_sync_subformat_e       subformat_i,
    // last cycle and this cycle trap info
    input  logic [`TE_CAUSE_LEN-1:0]         lc_cause_i,
    input  logic [`TE_XLEN-1:0]              lc_tval_i,
    input  logic                             lc_interrupt_i,
    input  logic [`TE_CAUSE_LEN-1:0]         tc_cause_i,
    input  logic [`TE_XLEN-1:0]              tc_tval_i,
    input  logic                             tc_interrupt_i,
    input  logic                             lc_tc_mux_i,
    // start packet
    input  logic                             tc_branch_i,
    input  logic                             tc_branch_taken_i,
    input  logic [`TE_PRIV_LEN-1:0]          tc_priv_i,
    input  logic [`TE_XLEN-1:0]              tc_iaddr_i,
    // trap packet address
    input  logic                             thaddr_i,
    input  logic [`TE_XLEN-3:0]              tc_tvec_i,
    input  logic [`TE_XLEN-1:0]              lc_epc_i,
    // support packet
    input  logic                             tc_ienable_i,
    input  logic                             encoder_mode_i,
    input  te_pkg::te_qual_status_e          qual_status_i,
    input  te_pkg::te_ioptions_e             ioptions_i,
    // formats 1 and 2
    input  logic                             lc_updiscon_i,
    input  logic [`TE_BRANCH_COUNT_LEN-1:0]  branches_i,
    input  logic [`TE_BRANCH_MAP_LEN-1:0]    branch_map_i,
    input  logic [`TE_KEEP_BITS_LEN-1:0]     keep_bits_i,
    output logic                             packet_valid_o,
    output logic [`TE_PAYLOAD_LEN-1:0]       packet_payload_o,
    output logic [`TE_P_LEN-1:0]             payload_length_o,
    output logic                             branch_map_flush_o,
    output logic [`TE_XLEN-1:0]              addr_to_compress_o
);

    te_fields_if fields_bus ();
    te_addr_if   addr_bus ();

    te_field_select i_field_select (
        .lc_cause_i        (lc_cause_i),
        .tc_cause_i        (tc_cause_i),
        .lc_tval_i         (lc_tval_i),
        .tc_tval_i         (tc_tval_i),
        .tc_iaddr_i        (tc_iaddr_i),
        .lc_interrupt_i    (lc_interrupt_i),
        .tc_interrupt_i    (tc_interrupt_i),
        .lc_tc_mux_i       (lc_tc_mux_i),
        .tc_branch_i       (tc_branch_i),
        .tc_branch_taken_i (tc_branch_taken_i),
        .lc_updiscon_i     (lc_updiscon_i),
        .fields_o          (fields_bus.sel)
    );

    // holds the last address sent
    te_addr_unit i_addr_unit (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .tc_iaddr_i  (tc_iaddr_i),
        .lc_epc_i    (lc_epc_i),
        .tc_tvec_i   (tc_tvec_i),
        .thaddr_i    (thaddr_i),
        .keep_bits_i (keep_bits_i),
        .addr_o      (addr_bus.unit)
    );

    te_payload_packer i_payload_packer (
        .valid_i            (valid_i),
        .format_i           (format_i),
        .subformat_i        (subformat_i),
        .tc_priv_i          (tc_priv_i),
        .tc_iaddr_i         (tc_iaddr_i),
        .tc_ienable_i       (tc_ienable_i),
        .encoder_mode_i     (encoder_mode_i),
        .qual_status_i      (qual_status_i),
        .ioptions_i         (ioptions_i),
        .branches_i         (branches_i),
        .branch_map_i       (branch_map_i),
        .fields_i           (fields_bus.pack),
        .addr_i             (addr_bus.pack),
        .packet_valid_o     (packet_valid_o),
        .branch_map_flush_o (branch_map_flush_o),
        .packet_payload_o   (packet_payload_o),
        .payload_length_o   (payload_length_o),
        .addr_to_compress_o (addr_to_compress_o)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_te_packet_emitter -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "^>>> PASS$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tb.f */
+incdir+common
common/te_pkg.sv
common/te_fields_if.sv
common/te_addr_if.sv
design/te_field_select.sv
design/te_addr_unit.sv
design/packer/te_payload_packer.sv
design/te_packet_emitter.sv
bench/tb_te_packet_emitter.sv
